/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cp0
LINT_TOP  ?= cp0_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --timing --timescale 1ns/10ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
hdl/cp0_pkg.sv
hdl/cp0_except_if.sv
hdl/cp0_exception_arbiter.sv
hdl/cp0_regs.sv
hdl/cp0_top.sv
test/tb_cp0.sv

/* hdl/cp0_except_if.sv */
`timescale 1ns/10ps

interface cp0_except_if;
    import cp0_pkg::*;

    logic      take;
    exc_code_e code;
    word_t     pc;
    logic      in_delay_slot;
    word_t     bad_vaddr;

    // Register state fed back for masking and vector choice
    word_t     status;
    word_t     cause;
    word_t     epc;

    modport arbiter (
        output take, code, pc, in_delay_slot, bad_vaddr,
        input  status, cause, epc
    );

    modport regs (
        input  take, code, pc, in_delay_slot, bad_vaddr,
        output status, cause, epc
    );

endinterface

/* hdl/cp0_exception_arbiter.sv */
`timescale 1ns/10ps

module cp0_exception_arbiter (
    input  logic                commit_valid_i,
    input  cp0_pkg::word_t      commit_pc_i,
    input  logic                commit_delay_slot_i,
    input  cp0_pkg::exc_flags_t commit_exc_i,
    input  logic                commit_store_i,
    input  cp0_pkg::word_t      commit_mem_addr_i,
    input  logic                commit_eret_i,
    cp0_except_if.arbiter       exc,
    output logic                take_exc_o,
    output cp0_pkg::word_t      exc_vector_o
);
    import cp0_pkg::*;

    logic       bev;
    logic       iv;
    logic [7:0] int_lines;
    logic       int_pending;
    word_t      gen_vector;
    word_t      int_vector;

    assign bev = exc.status[SR_BEV];
    assign iv  = exc.cause[CR_IV];

    // IP masked by IM
    assign int_lines = exc.cause[15:8] & exc.status[15:8];

    assign int_pending = exc.status[SR_IE] & ~exc.status[SR_EXL] &
                         ~exc.status[SR_ERL] & (|int_lines);

    assign exc.pc            = commit_pc_i;
    assign exc.in_delay_slot = commit_delay_slot_i;

    // Fixed priority, interrupt first and eret last
    always_comb begin
        exc.take      = 1'b0;
        exc.code      = INT;
        exc.bad_vaddr = commit_mem_addr_i;
        if (commit_valid_i) begin
            exc.take = 1'b1;
            if (int_pending) begin
                exc.code = INT;
            end else if (commit_exc_i[EXF_FETCH_ADDR]) begin
                exc.code      = ADEL;
                exc.bad_vaddr = commit_pc_i;
            end else if (commit_exc_i[EXF_RI]) begin
                exc.code = RI;
            end else if (commit_exc_i[EXF_SYS]) begin
                exc.code = SYS;
            end else if (commit_exc_i[EXF_BP]) begin
                exc.code = BP;
            end else if (commit_exc_i[EXF_OV]) begin
                exc.code = OV;
            end else if (commit_exc_i[EXF_TR]) begin
                exc.code = TR;
            end else if (commit_exc_i[EXF_DATA_ADDR]) begin
                if (commit_store_i) begin
                    exc.code = ADES;
                end else begin
                    exc.code = ADEL;
                end
            end else if (commit_eret_i) begin
                exc.code = ERET;
            end else begin
                exc.take = 1'b0;
            end
        end
    end

    assign gen_vector = bev ? VEC_BEV_GEN : VEC_GEN;

    // IV only moves the interrupt entry, BEV picks the boot table
    assign int_vector = iv ? (bev ? VEC_BEV_INT_IV : VEC_INT_IV) : gen_vector;

    always_comb begin
        case (exc.code)
            ERET:    exc_vector_o = exc.epc;
            INT:     exc_vector_o = int_vector;
            default: exc_vector_o = gen_vector;
        endcase
    end

    assign take_exc_o = exc.take;

endmodule

/* hdl/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [6:0]  exc_flags_t;

    typedef enum reg_addr_t {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        ENTRYHI  = 5'd10,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        PRID     = 5'd15,
        CONFIG   = 5'd16
    } cp0_reg_e;

    // ERET is an internal marker only, never lands in ExcCode
    typedef enum exc_code_t {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12,
        TR   = 5'd13,
        ERET = 5'd31
    } exc_code_e;

    // Raw flag positions in exc_flags_t
    localparam int unsigned EXF_FETCH_ADDR = 0;
    localparam int unsigned EXF_RI         = 1;
    localparam int unsigned EXF_SYS        = 2;
    localparam int unsigned EXF_BP         = 3;
    localparam int unsigned EXF_OV         = 4;
    localparam int unsigned EXF_TR         = 5;
    localparam int unsigned EXF_DATA_ADDR  = 6;

    // Status and Cause bit positions
    localparam int unsigned SR_IE  = 0;
    localparam int unsigned SR_EXL = 1;
    localparam int unsigned SR_ERL = 2;
    localparam int unsigned SR_BEV = 22;
    localparam int unsigned CR_WP  = 22;
    localparam int unsigned CR_IV  = 23;
    localparam int unsigned CR_BD  = 31;

    localparam word_t STATUS_RESET = 32'h0040_0000;
    localparam word_t PRID_VALUE   = 32'h0001_9300;
    localparam word_t CONFIG_VALUE = 32'h0000_0000;

    localparam word_t VEC_BEV_GEN    = 32'hbfc0_0380;
    localparam word_t VEC_BEV_INT_IV = 32'hbfc0_0400;
    localparam word_t VEC_GEN        = 32'h8000_0180;
    localparam word_t VEC_INT_IV     = 32'h8000_0200;

endpackage

/* hdl/cp0_regs.sv */
`timescale 1ns/10ps

module cp0_regs #(
    parameter cp0_pkg::word_t PRID_WORD   = cp0_pkg::PRID_VALUE,
    parameter cp0_pkg::word_t CONFIG_WORD = cp0_pkg::CONFIG_VALUE
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [5:0]         hw_int_i,
    input  logic               sw_we_i,
    input  cp0_pkg::reg_addr_t sw_waddr_i,
    input  cp0_pkg::word_t     sw_wdata_i,
    input  cp0_pkg::reg_addr_t sw_raddr_i,
    output cp0_pkg::word_t     sw_rdata_o,
    cp0_except_if.regs         exc,
    output logic               timer_int_o,
    output logic               user_mode_o,
    output cp0_pkg::word_t     status_o
);
    import cp0_pkg::*;

    word_t count_q;
    word_t compare_q;
    word_t status_q;
    word_t cause_q;
    word_t epc_q;
    word_t badvaddr_q;
    word_t entryhi_q;
    logic  timer_int_q;
    logic  exc_entry;
    logic  addr_error;
    word_t epc_next;

    // A real exception, not an eret
    assign exc_entry  = exc.take && (exc.code != ERET);
    assign addr_error = (exc.code == ADEL) || (exc.code == ADES);

    // Delay slot faults restart at the branch
    assign epc_next = exc.in_delay_slot ? (exc.pc - 32'd4) : exc.pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            compare_q   <= '0;
            status_q    <= STATUS_RESET;
            cause_q     <= '0;
            epc_q       <= '0;
            badvaddr_q  <= '0;
            entryhi_q   <= '0;
            timer_int_q <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;

            // IP7..2 track the lines, timer shares IP7
            cause_q[15:10] <= {hw_int_i[5] | timer_int_q, hw_int_i[4:0]};

            if ((compare_q != '0) && (count_q == compare_q)) begin
                timer_int_q <= 1'b1;
            end

            if (sw_we_i) begin
                case (sw_waddr_i)
                    COUNT: begin
                        count_q <= sw_wdata_i;
                    end
                    COMPARE: begin
                        compare_q   <= sw_wdata_i;
                        timer_int_q <= 1'b0;
                    end
                    ENTRYHI: begin
                        // VPN2 and ASID
                        entryhi_q[31:13] <= sw_wdata_i[31:13];
                        entryhi_q[7:0]   <= sw_wdata_i[7:0];
                    end
                    STATUS: begin
                        status_q[SR_BEV] <= sw_wdata_i[SR_BEV];
                        status_q[15:8]   <= sw_wdata_i[15:8];
                        status_q[SR_EXL] <= sw_wdata_i[SR_EXL];
                        status_q[SR_IE]  <= sw_wdata_i[SR_IE];
                    end
                    CAUSE: begin
                        // Software interrupts IP1..0
                        cause_q[9:8]  <= sw_wdata_i[9:8];
                        cause_q[CR_IV] <= sw_wdata_i[CR_IV];
                        cause_q[CR_WP] <= sw_wdata_i[CR_WP];
                    end
                    EPC: begin
                        epc_q <= sw_wdata_i;
                    end
                    default: begin
                    end
                endcase
            end

            // Placed after the software write so the exception wins
            if (exc_entry) begin
                status_q[SR_EXL] <= 1'b1;
                cause_q[6:2]     <= exc.code;
                // Nested faults keep the first EPC
                if (!status_q[SR_EXL]) begin
                    epc_q          <= epc_next;
                    cause_q[CR_BD] <= exc.in_delay_slot;
                end
                if (addr_error) begin
                    badvaddr_q <= exc.bad_vaddr;
                end
            end else if (exc.take) begin
                status_q[SR_EXL] <= 1'b0;
            end
        end
    end

    always_comb begin
        case (sw_raddr_i)
            BADVADDR: sw_rdata_o = badvaddr_q;
            COUNT:    sw_rdata_o = count_q;
            ENTRYHI:  sw_rdata_o = entryhi_q;
            COMPARE:  sw_rdata_o = compare_q;
            STATUS:   sw_rdata_o = status_q;
            CAUSE:    sw_rdata_o = cause_q;
            EPC:      sw_rdata_o = epc_q;
            PRID:     sw_rdata_o = PRID_WORD;
            CONFIG:   sw_rdata_o = CONFIG_WORD;
            default:  sw_rdata_o = '0;
        endcase
    end

    assign exc.status = status_q;
    assign exc.cause  = cause_q;
    assign exc.epc    = epc_q;

    // KSU=10 with EXL and ERL clear
    assign user_mode_o = (status_q[4:3] == 2'b10) && !status_q[SR_EXL] && !status_q[SR_ERL];

    assign timer_int_o = timer_int_q;
    assign status_o    = status_q;

endmodule

/* hdl/cp0_top.sv */
`timescale 1ns/10ps

module cp0_top #(
    parameter cp0_pkg::word_t PRID_WORD   = cp0_pkg::PRID_VALUE,
    parameter cp0_pkg::word_t CONFIG_WORD = cp0_pkg::CONFIG_VALUE
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                commit_valid_i,
    input  cp0_pkg::word_t      commit_pc_i,
    input  logic                commit_delay_slot_i,
    input  cp0_pkg::exc_flags_t commit_exc_i,
    input  logic                commit_store_i,
    input  cp0_pkg::word_t      commit_mem_addr_i,
    input  logic                commit_eret_i,

    input  logic [5:0]          hw_int_i,

    input  logic                sw_we_i,
    input  cp0_pkg::reg_addr_t  sw_waddr_i,
    input  cp0_pkg::word_t      sw_wdata_i,
    input  cp0_pkg::reg_addr_t  sw_raddr_i,
    output cp0_pkg::word_t      sw_rdata_o,

    output logic                take_exc_o,
    output cp0_pkg::word_t      exc_vector_o,
    output logic                user_mode_o,
    output logic                timer_int_o,
    output cp0_pkg::word_t      status_o
);

    cp0_except_if exc ();

    cp0_exception_arbiter u_arbiter (
        .commit_valid_i      (commit_valid_i),
        .commit_pc_i         (commit_pc_i),
        .commit_delay_slot_i (commit_delay_slot_i),
        .commit_exc_i        (commit_exc_i),
        .commit_store_i      (commit_store_i),
        .commit_mem_addr_i   (commit_mem_addr_i),
        .commit_eret_i       (commit_eret_i),
        .exc                 (exc.arbiter),
        .take_exc_o          (take_exc_o),
        .exc_vector_o        (exc_vector_o)
    );

    cp0_regs #(
        .PRID_WORD   (PRID_WORD),
        .CONFIG_WORD (CONFIG_WORD)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .hw_int_i    (hw_int_i),
        .sw_we_i     (sw_we_i),
        .sw_waddr_i  (sw_waddr_i),
        .sw_wdata_i  (sw_wdata_i),
        .sw_raddr_i  (sw_raddr_i),
        .sw_rdata_o  (sw_rdata_o),
        .exc         (exc.regs),
        .timer_int_o (timer_int_o),
        .user_mode_o (user_mode_o),
        .status_o    (status_o)
    );

endmodule

/* test/cp0_input.txt */
# Numbers in hex. write addr data | read addr mask exp | idle n | hwint lines | umode exp
# commit pc ctrl mem_addr take vector (ctrl: flags 6:0, dslot 8, store 9, eret 10) | wait-timer level max
test reset_masks
read c ffffffff 00400000
read f ffffffff 00019300
umode 0
write 9 00001000
read 9 ffffffff 00001000
idle 4
read 9 ffffffff 00001005
write c ffffffff
read c ffffffff 0040ff03
write d ffffffff
read d ffffffff 00c00300
write d 00000000
write c 00400000
read c ffffffff 00400000
test exception_entry
commit 80001004 104 00000000 1 bfc00380
read e ffffffff 80001000
read d 8000007c 80000020
read c ffffffff 00400002
test nested_eret
commit 80002000 240 12345671 1 bfc00380
read e ffffffff 80001000
read d 8000007c 80000014
read 8 ffffffff 12345671
commit 80002010 040 00000abc 1 bfc00380
read d 0000007c 00000010
read 8 ffffffff 00000abc
commit 80002020 400 00000000 1 80001000
read c ffffffff 00400000
test priority
commit 80004000 01e 00000000 1 bfc00380
read d 8000007c 00000028
read e ffffffff 80004000
commit 80004100 07f 00000000 1 bfc00380
read d 0000007c 00000010
read 8 ffffffff 80004100
commit 80004200 03c 00000000 1 bfc00380
read d 0000007c 00000020
commit 80004300 060 00000000 1 bfc00380
read d 0000007c 00000034
commit 80004400 440 00007777 1 bfc00380
read d 0000007c 00000010
read 8 ffffffff 00007777
commit 80004500 000 00000000 0 00000000
commit 80004600 400 00000000 1 80004000
read c ffffffff 00400000
test timer
write 9 00002000
write b 00002010
wait-timer 1 28
read d 00008000 00008000
write b 00000000
wait-timer 0 4
read d 00008000 00000000
test int_vectors
hwint 01
write c 00400401
read d 0000fc00 00000400
commit 80003000 000 00000000 1 bfc00380
read d 0000007c 00000000
commit 80003004 400 00000000 1 80003000
write d 00800000
commit 80003100 000 00000000 1 bfc00400
commit 80003104 400 00000000 1 80003100
write c 00000401
write d 00000000
commit 80003200 000 00000000 1 80000180
commit 80003204 400 00000000 1 80003200
write d 00800000
commit 80003300 000 00000000 1 80000200
commit 80003304 400 00000000 1 80003300
hwint 00
write c 00400000

/* test/tb_cp0.sv */
`timescale 1ns/10ps

module tb_cp0;

    localparam int PERIOD  = 40;
    localparam int MAX_OPS = 1000;

    logic        clk;
    logic        rst;
    logic        commit_valid_i;
    logic [31:0] commit_pc_i;
    logic        commit_delay_slot_i;
    logic [6:0]  commit_exc_i;
    logic        commit_store_i;
    logic [31:0] commit_mem_addr_i;
    logic        commit_eret_i;
    logic [5:0]  hw_int_i;
    logic        sw_we_i;
    logic [4:0]  sw_waddr_i;
    logic [31:0] sw_wdata_i;
    logic [4:0]  sw_raddr_i;
    logic [31:0] sw_rdata_o;
    logic        take_exc_o;
    logic [31:0] exc_vector_o;
    logic        user_mode_o;
    logic        timer_int_o;
    logic [31:0] status_o;

    integer         fd;
    int             errors;
    int             checks;
    int             tests;
    int             test_errors;
    logic           in_test;
    string          tag;
    string          test_name;
    reg [8*256-1:0] skip_line;
    logic [31:0]    field [0:4];

    cp0_top UUT (
        .clk                 (clk),
        .rst                 (rst),
        .commit_valid_i      (commit_valid_i),
        .commit_pc_i         (commit_pc_i),
        .commit_delay_slot_i (commit_delay_slot_i),
        .commit_exc_i        (commit_exc_i),
        .commit_store_i      (commit_store_i),
        .commit_mem_addr_i   (commit_mem_addr_i),
        .commit_eret_i       (commit_eret_i),
        .hw_int_i            (hw_int_i),
        .sw_we_i             (sw_we_i),
        .sw_waddr_i          (sw_waddr_i),
        .sw_wdata_i          (sw_wdata_i),
        .sw_raddr_i          (sw_raddr_i),
        .sw_rdata_o          (sw_rdata_o),
        .take_exc_o          (take_exc_o),
        .exc_vector_o        (exc_vector_o),
        .user_mode_o         (user_mode_o),
        .timer_int_o         (timer_int_o),
        .status_o            (status_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        checks = checks + 1;
        if (actual !== expected) begin
            errors      = errors + 1;
            test_errors = test_errors + 1;
            $display("Fail at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic read_fields(input int count);
        int got;
        for (int i = 0; i < count; i++) begin
            got = $fscanf(fd, "%h", field[i]);
            if (got != 1) begin
                errors = errors + 1;
                $display("Data file line for %s is missing field %0d", tag, i);
            end
        end
    endtask

    // Strobes last one cycle only
    task automatic clear_strobes;
        commit_valid_i = 1'b0;
        commit_eret_i  = 1'b0;
        sw_we_i        = 1'b0;
    endtask

    task automatic report_test;
        if (in_test) begin
            if (test_errors == 0) begin
                $display("Test %s: passed", test_name);
            end else begin
                $display("Test %s: %0d errors", test_name, test_errors);
            end
        end
    endtask

    initial begin
        int   got;
        int   ops;
        logic done;
        logic seen;

        clk                 = 1'b0;
        rst                 = 1'b1;
        commit_pc_i         = '0;
        commit_delay_slot_i = 1'b0;
        commit_exc_i        = '0;
        commit_store_i      = 1'b0;
        commit_mem_addr_i   = '0;
        hw_int_i            = '0;
        sw_waddr_i          = '0;
        sw_wdata_i          = '0;
        sw_raddr_i          = '0;
        clear_strobes();
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        in_test     = 1'b0;

        fd = $fopen("test/cp0_input.txt", "r");
        if (fd == 0) begin
            errors = errors + 1;
            $display("Could not open the data file test/cp0_input.txt");
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        check_eq({31'd0, take_exc_o}, 32'd0, "take_exc_o after reset");
        check_eq({31'd0, timer_int_o}, 32'd0, "timer_int_o after reset");
        rst = 1'b0;

        ops  = 0;
        done = (fd == 0);
        while (!done) begin
            clear_strobes();
            got = $fscanf(fd, "%s", tag);
            ops = ops + 1;
            if (got != 1) begin
                done = 1'b1;
            end else if (ops > MAX_OPS) begin
                errors = errors + 1;
                $display("Data file has more than %0d operations, stopping", MAX_OPS);
                done = 1'b1;
            end else if (tag == "#") begin
                got = $fgets(skip_line, fd);
            end else if (tag == "test") begin
                report_test();
                got         = $fscanf(fd, "%s", test_name);
                tests       = tests + 1;
                test_errors = 0;
                in_test     = 1'b1;
            end else if (tag == "write") begin
                read_fields(2);
                sw_we_i    = 1'b1;
                sw_waddr_i = field[0][4:0];
                sw_wdata_i = field[1];
                @(negedge clk);
            end else if (tag == "read") begin
                read_fields(3);
                sw_raddr_i = field[0][4:0];
                #(PERIOD / 4);
                check_eq(sw_rdata_o & field[1], field[2],
                         $sformatf("read of register %0d", field[0]));
                // Status also leaves on its own port
                if (field[0][4:0] == cp0_pkg::STATUS) begin
                    check_eq(status_o & field[1], field[2], "status_o");
                end
                @(negedge clk);
            end else if (tag == "commit") begin
                // ctrl column: flags in 6:0, delay slot 8, store 9, eret 10
                read_fields(5);
                commit_valid_i      = 1'b1;
                commit_pc_i         = field[0];
                commit_exc_i        = field[1][6:0];
                commit_delay_slot_i = field[1][8];
                commit_store_i      = field[1][9];
                commit_eret_i       = field[1][10];
                commit_mem_addr_i   = field[2];
                #(PERIOD / 4);
                check_eq({31'd0, take_exc_o}, field[3],
                         $sformatf("take_exc_o for pc %h", field[0]));
                if (field[3] != 0) begin
                    check_eq(exc_vector_o, field[4],
                             $sformatf("exc_vector_o for pc %h", field[0]));
                end
                @(negedge clk);
            end else if (tag == "idle") begin
                read_fields(1);
                repeat (field[0]) @(negedge clk);
            end else if (tag == "wait-timer") begin
                read_fields(2);
                seen = 1'b0;
                for (int i = 0; i < field[1] && !seen; i++) begin
                    #(PERIOD / 4);
                    seen = (timer_int_o === field[0][0]);
                    @(negedge clk);
                end
                checks = checks + 1;
                if (!seen) begin
                    errors      = errors + 1;
                    test_errors = test_errors + 1;
                    $display("Timed out: timer_int_o did not become %0d within %0d cycles",
                             field[0][0], field[1]);
                end
            end else if (tag == "hwint") begin
                read_fields(1);
                hw_int_i = field[0][5:0];
                @(negedge clk);
            end else if (tag == "umode") begin
                read_fields(1);
                #(PERIOD / 4);
                check_eq({31'd0, user_mode_o}, field[0], "user_mode_o");
                @(negedge clk);
            end else begin
                errors = errors + 1;
                $display("Unknown operation %s in the data file", tag);
                got = $fgets(skip_line, fd);
            end
        end

        report_test();
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
